/* common/popeye_defs.svh */
// Bus widths and memory sizes for the main board, included by every file that sizes a port
`ifndef POPEYE_DEFS_SVH
`define POPEYE_DEFS_SVH

// Processor bus
`define POPEYE_AW 16 // Address width
`define POPEYE_DW 8  // Data width

// On-board memories
`define POPEYE_ROM_AW 15 // 32 KiB program ROM
`define POPEYE_RAM_AW 11 // 2 KiB work RAM

// Pull-ups on an unselected I/O port
`define POPEYE_IDLE_BYTE 8'hff

`endif

/* common/popeye_pkg.sv */
// Shared types for the main board: read-device and I/O port names, imported by the decoder and top
`default_nettype none

package popeye_pkg;

    //////////////////////////////////////////////////////////////////////
    // Device that owns the read bus
    typedef enum logic [2:0] {
        DEV_NONE, // Nothing selected, reads zero
        DEV_ROM,  // 32 KiB program ROM
        DEV_RAM,  // 2 KiB work RAM
        DEV_TXT,  // Text layer, not present here
        DEV_BG,   // Background layer, not present here
        DEV_SEC,  // Protection device
        DEV_IO    // I/O read cycle
    } dev_sel_e;

    //////////////////////////////////////////////////////////////////////
    // I/O read ports, low two logical address bits
    typedef enum logic [1:0] {
        IO_PSG = 2'd0, // Sound chip data
        IO_SYS = 2'd1, // Coin, service, start
        IO_P2  = 2'd2, // Player 2 controls
        IO_P1  = 2'd3  // Player 1 controls
    } io_port_e;

endpackage

`default_nettype wire

/* memory/popeye_sync_mem.sv */
// Byte-wide memory with a clock-enabled registered read, used for the program ROM and work RAM
`default_nettype none
`include "popeye_defs.svh"

module popeye_sync_mem #(
    parameter int aw = 11 // Address bits
) (
    input  wire                   clk,
    input  wire                   cen,     // Read strobe
    input  wire [aw-1:0]          rd_addr,
    input  wire [aw-1:0]          wr_addr,
    input  wire [`POPEYE_DW-1:0]  wr_data,
    input  wire                   we,
    output logic [`POPEYE_DW-1:0] q
);

    localparam int DEPTH = 2 ** aw;

    logic [`POPEYE_DW-1:0] mem [0:DEPTH-1];

    // Write port, any clk
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr]; // Old data on a same-cycle write
        end
    end

endmodule

`default_nettype wire

/* security/popeye_security.sv */
// Protection device of the main board: a two-byte shift register read through a bit window
`default_nettype none
`include "popeye_defs.svh"

module popeye_security (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   cen,
    input  wire                   sel,  // Top of the memory map
    input  wire                   wr_n,
    input  wire                   a0,   // Odd: offset, even: data
    input  wire  [`POPEYE_DW-1:0] din,
    output logic [`POPEYE_DW-1:0] dout
);

    logic [2*`POPEYE_DW-1:0] sreg;    // {high byte, low byte}
    logic [2:0]              offset;
    logic [2*`POPEYE_DW-1:0] shifted;

    //////////////////////////////////////////////////////////////////////
    // Register updates
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sreg   <= '0;
            offset <= '0;
        end else if (cen && sel && !wr_n) begin
            if (a0) begin
                offset <= din[2:0];
            end else begin
                // New byte on top, old top drops down
                sreg <= {din, sreg[2*`POPEYE_DW-1:`POPEYE_DW]};
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read window
    always_comb begin
        shifted = sreg << offset;                 // Low byte bits slide up
        dout    = shifted[2*`POPEYE_DW-1:`POPEYE_DW];
    end

endmodule

`default_nettype wire

/* verilog/popeye_addr_decode.sv */
// Undoes the board's address line permutation and decodes memory and I/O selects for the top
`default_nettype none
`include "popeye_defs.svh"

module popeye_addr_decode import popeye_pkg::*; (
    input  wire [`POPEYE_AW-1:0]  cpu_addr, // As wired on the board
    input  wire                   mreq_n,
    input  wire                   iorq_n,
    input  wire                   rd_n,
    input  wire                   dmcs,     // DMA owns the RAM
    output logic [`POPEYE_AW-1:0] addr,     // Logical address
    output dev_sel_e              mem_sel,
    output logic                  io_rd,
    output io_port_e              io_port
);

    //////////////////////////////////////////////////////////////////////
    // Address descrambling
    always_comb begin
        addr[2:0]   = ~cpu_addr[2:0];
        addr[3]     = ~cpu_addr[4];
        addr[4]     = ~cpu_addr[5];
        addr[5]     = ~cpu_addr[9];
        addr[6]     = cpu_addr[3];
        addr[7]     = cpu_addr[6];
        addr[8]     = cpu_addr[7];
        addr[9]     = cpu_addr[8];
        addr[15:10] = cpu_addr[15:10]; // Straight through
    end

    //////////////////////////////////////////////////////////////////////
    // Memory map, top three bits
    always_comb begin
        mem_sel = DEV_NONE;
        case (addr[15:13])
            3'b100: begin
                // Upper half of the 4 KiB window is not fitted
                if ((!mreq_n || dmcs) && !addr[11]) begin
                    mem_sel = DEV_RAM;
                end
            end
            3'b101: begin
                if (!mreq_n) begin
                    mem_sel = DEV_TXT;
                end
            end
            3'b110: begin
                if (!mreq_n) begin
                    mem_sel = DEV_BG;
                end
            end
            3'b111:  mem_sel = DEV_SEC; // No strobe qualifier
            default: mem_sel = DEV_ROM; // 0000-7fff
        endcase
    end

    // I/O read, port by low bits
    assign io_rd   = !iorq_n && !rd_n;
    assign io_port = io_port_e'(addr[1:0]);

endmodule

`default_nettype wire

/* verilog/popeye_io_ports.sv */
// Cabinet input multiplexer and the sound chip's bus interface and I/O ports, driven by the top
`default_nettype none
`include "popeye_defs.svh"

module popeye_io_ports import popeye_pkg::*; (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   cen2,          // Sound chip clock enable
    input  wire                   iorq_n,
    input  wire                   wr_n,
    input  wire                   io_rd,
    input  io_port_e              io_port,
    input  wire                   a0,
    input  wire  [`POPEYE_DW-1:0] din,
    input  wire  [4:0]            joystick1,     // Punch, up, down, left, right
    input  wire  [4:0]            joystick2,
    input  wire  [1:0]            start_button,
    input  wire                   coin_input,
    input  wire                   service,
    input  wire  [3:0]            dip_sw1,
    input  wire  [7:0]            dip_sw2,
    output logic [`POPEYE_DW-1:0] dout,
    output logic [`POPEYE_DW-1:0] ioa            // Port A, register 14
);

    localparam logic [3:0] REG_IOA = 4'd14;
    localparam logic [3:0] REG_IOB = 4'd15;

    logic                  io_wr;
    logic [3:0]            psg_addr;             // Address latch
    logic [`POPEYE_DW-1:0] psg_regs [0:15];
    logic [`POPEYE_DW-1:0] iob;                  // DIP byte into port B
    logic [`POPEYE_DW-1:0] psg_dout;

    assign io_wr = !iorq_n && !wr_n;

    //////////////////////////////////////////////////////////////////////
    // Sound chip bus side
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            psg_addr <= '0;
            for (int i = 0; i < 16; i++) begin
                psg_regs[i] <= '0;
            end
        end else if (cen2 && io_wr) begin
            if (a0) begin
                psg_addr <= din[3:0]; // Odd port latches address
            end else begin
                psg_regs[psg_addr] <= din;
            end
        end
    end

    assign ioa = psg_regs[REG_IOA];

    // DIP switches on port B, bank 2 one bit at a time
    always_comb begin
        iob[3:0] = dip_sw1;
        iob[6:4] = 3'b000;
        iob[7]   = dip_sw2[ioa[3:1]];
    end

    // Port B is input only
    assign psg_dout = (psg_addr == REG_IOB) ? iob : psg_regs[psg_addr];

    //////////////////////////////////////////////////////////////////////
    // Cabinet multiplexer
    always_comb begin
        dout = `POPEYE_IDLE_BYTE;
        if (io_rd) begin
            case (io_port)
                IO_PSG: dout = psg_dout;
                IO_SYS: begin
                    dout[7]   = coin_input;
                    dout[6]   = service;
                    dout[3:2] = start_button;
                end
                IO_P2: begin
                    dout[1:0] = joystick2[1:0];
                    dout[2]   = joystick2[3]; // Up and down swap
                    dout[3]   = joystick2[2];
                    dout[4]   = joystick2[4];
                end
                IO_P1: begin
                    dout[1:0] = joystick1[1:0];
                    dout[2]   = joystick1[3];
                    dout[3]   = joystick1[2];
                    dout[4]   = joystick1[4];
                end
                default: dout = `POPEYE_IDLE_BYTE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/popeye_main.sv */
// Main board top without the processor core; the bus pins are inputs so a testbench drives them
`default_nettype none
`include "popeye_defs.svh"

module popeye_main import popeye_pkg::*; (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      cen4,
    input  wire                      cen2,
    // Processor bus, address still scrambled
    input  wire [`POPEYE_AW-1:0]     cpu_addr,
    input  wire [`POPEYE_DW-1:0]     cpu_dout,
    input  wire                      mreq_n,
    input  wire                      iorq_n,
    input  wire                      rd_n,
    input  wire                      wr_n,
    output logic [`POPEYE_DW-1:0]    cpu_din,
    // DMA
    input  wire                      dmcs,
    output logic                     memwro,
    // Cabinet
    input  wire [4:0]                joystick1,
    input  wire [4:0]                joystick2,
    input  wire [1:0]                start_button,
    input  wire                      coin_input,
    input  wire                      service,
    input  wire [3:0]                dip_sw1,
    input  wire [7:0]                dip_sw2,
    // ROM loader
    input  wire [`POPEYE_ROM_AW-1:0] prog_addr,
    input  wire [`POPEYE_DW-1:0]     prog_data,
    input  wire                      prom_we,
    // Misc
    output logic                     rv_n,    // Screen flip
    output logic                     cpu_cen,
    output logic [`POPEYE_DW-1:0]    psg_ioa
);

    logic [`POPEYE_AW-1:0] addr;
    dev_sel_e              mem_sel;
    dev_sel_e              mem_sel_l; // Select seen at the last cen4
    dev_sel_e              rd_src;
    io_port_e              io_port;
    logic                  io_rd;
    logic                  ram_we;
    logic [`POPEYE_DW-1:0] rom_q, ram_q, sec_dout, io_dout;

    assign cpu_cen = cen4;
    assign memwro  = ~wr_n & ~mreq_n;
    assign rv_n    = ~psg_ioa[0];

    popeye_addr_decode u_decode (
        .cpu_addr ( cpu_addr ),
        .mreq_n   ( mreq_n   ),
        .iorq_n   ( iorq_n   ),
        .rd_n     ( rd_n     ),
        .dmcs     ( dmcs     ),
        .addr     ( addr     ),
        .mem_sel  ( mem_sel  ),
        .io_rd    ( io_rd    ),
        .io_port  ( io_port  )
    );

    //////////////////////////////////////////////////////////////////////
    // Program ROM, written only by the loader
    popeye_sync_mem #(.aw(`POPEYE_ROM_AW)) u_rom (
        .clk     ( clk                      ),
        .cen     ( cen4                     ),
        .rd_addr ( addr[`POPEYE_ROM_AW-1:0] ),
        .wr_addr ( prog_addr                ),
        .wr_data ( prog_data                ),
        .we      ( prom_we                  ),
        .q       ( rom_q                    )
    );

    //////////////////////////////////////////////////////////////////////
    // Work RAM, bus or DMA
    assign ram_we = cen4 && (mem_sel == DEV_RAM) && !wr_n;

    popeye_sync_mem #(.aw(`POPEYE_RAM_AW)) u_ram (
        .clk     ( clk                      ),
        .cen     ( cen4                     ),
        .rd_addr ( addr[`POPEYE_RAM_AW-1:0] ),
        .wr_addr ( addr[`POPEYE_RAM_AW-1:0] ),
        .wr_data ( cpu_dout                 ),
        .we      ( ram_we                   ),
        .q       ( ram_q                    )
    );

    popeye_security u_security (
        .clk    ( clk                 ),
        .arst_n ( arst_n              ),
        .cen    ( cen4                ),
        .sel    ( mem_sel == DEV_SEC  ),
        .wr_n   ( wr_n                ),
        .a0     ( addr[0]             ),
        .din    ( cpu_dout            ),
        .dout   ( sec_dout            )
    );

    popeye_io_ports u_io (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .cen2         ( cen2         ),
        .iorq_n       ( iorq_n       ),
        .wr_n         ( wr_n         ),
        .io_rd        ( io_rd        ),
        .io_port      ( io_port      ),
        .a0           ( addr[0]      ),
        .din          ( cpu_dout     ),
        .joystick1    ( joystick1    ),
        .joystick2    ( joystick2    ),
        .start_button ( start_button ),
        .coin_input   ( coin_input   ),
        .service      ( service      ),
        .dip_sw1      ( dip_sw1      ),
        .dip_sw2      ( dip_sw2      ),
        .dout         ( io_dout      ),
        .ioa          ( psg_ioa      )
    );

    //////////////////////////////////////////////////////////////////////
    // Read data
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_sel_l <= DEV_NONE;
        end else if (cen4) begin
            mem_sel_l <= mem_sel; // Lines up with the registered memory q
        end
    end

    always_comb begin
        rd_src = io_rd ? DEV_IO : mem_sel; // I/O cycle wins over memory decode
        case (rd_src)
            DEV_IO:  cpu_din = io_dout;
            DEV_SEC: cpu_din = sec_dout;
            DEV_ROM, DEV_RAM: begin
                case (mem_sel_l)
                    DEV_ROM: cpu_din = rom_q;
                    DEV_RAM: cpu_din = ram_q;
                    default: cpu_din = '0; // Select just changed
                endcase
            end
            default: cpu_din = '0; // Text, background, nothing
        endcase
    end

endmodule

`default_nettype wire

/* verification/popeye_checker.sv */
// Board model beside the DUT that mirrors ROM, RAM, security and sound chip ports and checks outputs
`default_nettype none
`include "popeye_defs.svh"

module popeye_checker import popeye_pkg::*; (
    input  wire                      clk, arst_n, cen4, cen2,
    input  wire [`POPEYE_AW-1:0]     cpu_addr,
    input  wire [`POPEYE_DW-1:0]     cpu_dout, cpu_din, psg_ioa, prog_data,
    input  wire                      mreq_n, iorq_n, rd_n, wr_n, dmcs, prom_we,
    input  wire                      memwro, rv_n, cpu_cen, coin_input, service,
    input  wire [4:0]                joystick1, joystick2,
    input  wire [1:0]                start_button,
    input  wire [3:0]                dip_sw1,
    input  wire [7:0]                dip_sw2,
    input  wire [`POPEYE_ROM_AW-1:0] prog_addr,
    output int                       check_errors
);

    logic [7:0]  rom [0:(1 << `POPEYE_ROM_AW)-1]; // Loader image
    logic [7:0]  ram [0:(1 << `POPEYE_RAM_AW)-1];
    logic [7:0]  sec_hi, sec_lo;                  // Security shift register
    logic [2:0]  sec_off;
    logic [3:0]  psg_latch;
    logic [7:0]  psg_reg [0:15];
    logic [20:0] last_bus;                        // Bus at the previous cen4
    logic        last_ok;

    function automatic logic [15:0] descramble(input logic [15:0] c);
        return {c[15:10], c[8], c[7], c[6], c[3], ~c[9], ~c[5], ~c[4], ~c[2:0]};
    endfunction

    // Right, left, up, down, punch, pull-ups on top
    function automatic logic [7:0] player_byte(input logic [4:0] j);
        return {3'b111, j[4], j[2], j[3], j[1:0]};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Expected read byte for logical address a
    function automatic logic [7:0] expected_read(input logic [15:0] a);
        logic [7:0] fill;
        if (!iorq_n) begin
            case (a[1:0])
                IO_PSG:  return (psg_latch == 4'd15) ?
                                {dip_sw2[psg_reg[14][3:1]], 3'b000, dip_sw1} : psg_reg[psg_latch];
                IO_SYS:  return {coin_input, service, 2'b11, start_button, 2'b11};
                IO_P2:   return player_byte(joystick2);
                default: return player_byte(joystick1);
            endcase
        end
        case (a[15:13])
            3'b100:         return a[11] ? 8'h00 : ram[a[10:0]]; // Upper 2 KiB empty
            3'b101, 3'b110: return 8'h00;                        // Video layers not modelled
            3'b111: begin
                fill = sec_lo >> (4'd8 - {1'b0, sec_off});      // Low byte slides in
                return (sec_hi << sec_off) | fill;
            end
            default:        return rom[a[14:0]];
        endcase
    endfunction

    task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED time %0t %s: got %h expected %h", $time, name, got, exp);
            check_errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare against pre-edge values, then step the models
    always @(posedge clk or negedge arst_n) begin
        logic [15:0] a;
        logic [20:0] bus;
        a   = descramble(cpu_addr);
        bus = {cpu_addr, mreq_n, iorq_n, rd_n, wr_n, dmcs};
        if (!arst_n) begin
            sec_hi    = 8'h00;
            sec_lo    = 8'h00;
            sec_off   = 3'd0;
            psg_latch = 4'd0;
            last_ok   = 1'b0;
            for (int i = 0; i < 16; i++) psg_reg[i] = 8'h00;
        end else begin
            compare_byte("memwro", {7'd0, memwro}, {7'd0, !wr_n && !mreq_n});
            compare_byte("rv_n", {7'd0, rv_n}, {7'd0, ~psg_reg[14][0]});
            compare_byte("cpu_cen", {7'd0, cpu_cen}, {7'd0, cen4});
            compare_byte("psg_ioa", psg_ioa, psg_reg[14]);
            if (prom_we) rom[prog_addr] = prog_data;
            if (cen4) begin
                // Second strobe of a held read cycle
                if (!rd_n && (!mreq_n || !iorq_n || dmcs) && last_ok && bus == last_bus) begin
                    compare_byte("cpu_din", cpu_din, expected_read(a));
                end
                last_bus = bus;
                last_ok  = 1'b1;
                if (!wr_n && a[15:13] == 3'b100 && (!mreq_n || dmcs) && !a[11]) begin
                    ram[a[10:0]] = cpu_dout;
                end
                if (!wr_n && a[15:13] == 3'b111) begin
                    if (a[0]) begin
                        sec_off = cpu_dout[2:0];
                    end else begin
                        sec_lo = sec_hi;   // Old top drops down
                        sec_hi = cpu_dout;
                    end
                end
            end
            if (cen2 && !iorq_n && !wr_n) begin
                if (a[0]) psg_latch = cpu_dout[3:0];
                else psg_reg[psg_latch] = cpu_dout;
            end
        end
    end

endmodule

`default_nettype wire

/* verification/popeye_main_tb.sv */
// Testbench top: acts as the processor on the main board bus, then reports the result of the run
`default_nettype none
`include "popeye_defs.svh"

module popeye_main_tb;

    logic                      clk = 1'b0;
    logic [1:0]                phase = 2'd0;     // Strobe divider
    logic                      cen4 = 1'b0;
    logic                      cen2 = 1'b0;
    logic                      arst_n;
    logic [`POPEYE_AW-1:0]     cpu_addr;
    logic [`POPEYE_DW-1:0]     cpu_dout, cpu_din, psg_ioa, prog_data;
    logic                      mreq_n, iorq_n, rd_n, wr_n, dmcs, prom_we;
    logic                      memwro, rv_n, cpu_cen, coin_input, service;
    logic [4:0]                joystick1, joystick2;
    logic [1:0]                start_button;
    logic [3:0]                dip_sw1;
    logic [7:0]                dip_sw2;
    logic [`POPEYE_ROM_AW-1:0] prog_addr;
    int                        check_errors;     // From the checker
    int                        timeouts;

    popeye_main    u_dut     (.*);
    popeye_checker u_checker (.*);

    always #20 clk = ~clk;

    // cen4 on every second clk, cen2 on every second cen4
    always @(posedge clk) begin
        phase <= phase + 2'd1;
        cen4  <= phase[0];
        cen2  <= (phase == 2'd3);
    end

    task automatic finish_run();
        $display("Run ended: %0d check errors, %0d timeouts", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    task automatic wait_cen4();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!cen4 && n < 8);
        if (!cen4) begin
            $display("No cen4 strobe within 8 clocks at time %0t", $time);
            timeouts++;
            finish_run();
        end
    endtask

    // Inverse of the board's address line permutation
    function automatic logic [15:0] scramble(input logic [15:0] a);
        logic [15:0] c;
        c[2:0]   = ~a[2:0];
        c[3]     = a[6];
        c[4]     = ~a[3];
        c[5]     = ~a[4];
        c[6]     = a[7];
        c[7]     = a[8];
        c[8]     = a[9];
        c[9]     = ~a[5];
        c[15:10] = a[15:10];
        return c;
    endfunction

    task automatic drive_idle();
        mreq_n <= 1'b1;
        iorq_n <= 1'b1;
        rd_n   <= 1'b1;
        wr_n   <= 1'b1;
        dmcs   <= 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // One bus cycle over two cen4 strobes, then an idle strobe
    task automatic bus_cycle(input logic [15:0] a, input logic [7:0] d, input logic io,
                             input logic wr, input logic dma);
        cpu_addr <= scramble(a);
        cpu_dout <= d;
        mreq_n   <= io | dma;
        iorq_n   <= ~io;
        dmcs     <= dma;
        rd_n     <= wr;
        wr_n     <= ~(wr & io);     // I/O write spans both strobes, one of them has cen2
        wait_cen4();
        wr_n     <= ~wr;            // Memory write on the second strobe only
        wait_cen4();
        drive_idle();
        wait_cen4();
    endtask

    task automatic mem_rd(input logic [15:0] a, input logic dma);
        bus_cycle(a, 8'h00, 1'b0, 1'b0, dma);
    endtask

    task automatic mem_wr(input logic [15:0] a, input logic [7:0] d, input logic dma);
        bus_cycle(a, d, 1'b0, 1'b1, dma);
    endtask

    task automatic io_rd(input logic [15:0] a);
        bus_cycle(a, 8'h00, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic io_wr(input logic [15:0] a, input logic [7:0] d);
        bus_cycle(a, d, 1'b1, 1'b1, 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    initial begin
        void'($urandom(32'hbf00_5c3b));
        arst_n <= 1'b0;
        drive_idle();
        cpu_addr     <= '0;
        cpu_dout     <= '0;
        prom_we      <= 1'b0;
        prog_addr    <= '0;
        prog_data    <= '0;
        joystick1    <= '0;
        joystick2    <= '0;
        start_button <= '0;
        coin_input   <= 1'b0;
        service      <= 1'b0;
        dip_sw1      <= '0;
        dip_sw2      <= '0;
        for (int i = 0; i < 3; i++) @(posedge clk);
        arst_n <= 1'b1;
        wait_cen4();
        mem_rd(16'he000, 1'b0);                       // Security window reads zero
        for (int i = 0; i < (1 << `POPEYE_ROM_AW); i++) begin
            prom_we   <= 1'b1;                        // Whole ROM image, random
            prog_addr <= 15'(i);
            prog_data <= 8'($urandom);
            @(posedge clk);
        end
        prom_we <= 1'b0;
        for (int i = 0; i < 64; i++) mem_rd(16'($urandom & 32'h7fff), 1'b0);
        for (int i = 0; i < (1 << `POPEYE_RAM_AW); i++) mem_wr(16'h8000 | 16'(i), 8'($urandom), 1'b0);
        for (int i = 0; i < 96; i++) begin
            if ($urandom % 2 == 0) begin                // Bit 11 set now and then
                mem_wr(16'h8000 | 16'($urandom & 32'h0fff), 8'($urandom), i >= 64);
            end else begin
                mem_rd(16'h8000 | 16'($urandom & 32'h0fff), i >= 64);
            end
        end
        for (int i = 0; i < 32; i++) begin
            mem_wr(16'he001, 8'($urandom), 1'b0);     // Offset
            for (int k = 0; k <= int'($urandom % 3); k++) mem_wr(16'he000, 8'($urandom), 1'b0);
            mem_rd(16'he000, 1'b0);
        end
        for (int i = 0; i < 32; i++) begin
            joystick1    <= 5'($urandom);
            joystick2    <= 5'($urandom);
            start_button <= 2'($urandom);
            coin_input   <= 1'($urandom);
            service      <= 1'($urandom);
            io_rd(16'(1 + $urandom % 3));
        end
        for (int s = 0; s < 8; s++) begin
            dip_sw1 <= 4'($urandom);
            dip_sw2 <= 8'($urandom);
            io_wr(16'd1, 8'd14);                      // Port A, DIP bit select
            io_wr(16'd0, {4'($urandom), 3'(s), 1'($urandom)});
            io_rd(16'd0);
            io_wr(16'd1, 8'd15);                      // Port B
            io_rd(16'd0);
        end
        for (int r = 0; r < 14; r++) begin
            io_wr(16'd1, 8'(r));
            io_wr(16'd0, 8'($urandom));
            io_rd(16'd0);
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* popeye_main.f */
+incdir+common
common/popeye_pkg.sv
memory/popeye_sync_mem.sv
security/popeye_security.sv
verilog/popeye_addr_decode.sv
verilog/popeye_io_ports.sv
verilog/popeye_main.sv
verification/popeye_checker.sv
verification/popeye_main_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the main board testbench with Verilator, runs it and scans the log for the result
cd "$(dirname "$0")" || exit 1
log=sim.log
verilator --binary --timing --top-module popeye_main_tb -f popeye_main.f \
    -Mdir obj_dir -o popeye_main_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi
./obj_dir/popeye_main_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if grep -q "SIMULATION FAILED" "$log"; then
    exit 1
fi
exit 0
